//--- source/dvb_s2_defines.svh
`ifndef DVB_S2_DEFINES_SVH
`define DVB_S2_DEFINES_SVH

// bus widths
`define DVB_DATA_W 32
`define DVB_ADDR_W 4
`define DVB_SEL_W 4

// register word addresses
`define REG_MOD_MODE 4'd0
`define REG_FREQ_INV 4'd1
`define REG_SYS_FREQ 4'd2
`define REG_BAUD 4'd3
`define REG_ENABLE 4'd4
`define REG_TICK_CNT 4'd5
`define REG_LAST_SYM 4'd6

`define RST_SYS_FREQ 32'd10000
`define RST_BAUD 32'd2500

`define DVB_BAD_ADDR_TAG 16'hE000

// constellation
`define DVB_AMP (16'sd32767)
`define DVB_QPSK_AMP (16'sd23170)
`define DVB_MODE_8PSK 2'd1
`define DVB_BUF_W 16

`endif

//--- source/dvb_s2_pkg.sv
`default_nettype none

`include "dvb_s2_defines.svh"

package dvb_s2_pkg;

	// wishbone classic master side
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [`DVB_ADDR_W-1:0] adr;
		logic [`DVB_SEL_W-1:0] sel;
		logic [`DVB_DATA_W-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		logic [`DVB_DATA_W-1:0] dat;
	} wb_rsp_t;

	typedef struct packed {
		logic [1:0] mod_mode; // 0 qpsk, 1 8psk, others qpsk
		logic freq_inv; // swap i and q
		logic [31:0] sys_freq;
		logic [31:0] baud;
		logic enable;
	} mod_cfg_t;

	typedef struct packed {
		logic signed [15:0] re;
		logic signed [15:0] im;
	} symbol_t;

	// captured symbol as seen from the bus, re in the upper half
	typedef union packed {
		symbol_t sym;
		logic [`DVB_DATA_W-1:0] word;
	} sym_word_u;

endpackage

`default_nettype wire

//--- source/dvb_s2_cfg_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "dvb_s2_defines.svh"

module dvb_s2_cfg_regs (
	input wire clk,
	input wire rst_n,
	input wire dvb_s2_pkg::wb_req_t wb_req,
	output dvb_s2_pkg::wb_rsp_t wb_rsp,
	output dvb_s2_pkg::mod_cfg_t cfg,
	input wire tick_seen,
	input wire dvb_s2_pkg::symbol_t last_sym,
	input wire last_sym_valid
);

	logic ack_q;
	logic [`DVB_DATA_W-1:0] rdat_q;
	logic [`DVB_DATA_W-1:0] rd_word;
	logic [`DVB_DATA_W-1:0] wr_word;
	logic [`DVB_DATA_W-1:0] tick_cnt;
	logic access;
	dvb_s2_pkg::sym_word_u last_sym_q;

	function automatic logic [`DVB_DATA_W-1:0] merge_bytes(
		input logic [`DVB_DATA_W-1:0] old_word,
		input logic [`DVB_DATA_W-1:0] new_word,
		input logic [`DVB_SEL_W-1:0] sel
	);
		logic [`DVB_DATA_W-1:0] res;
		res = old_word;
		for (int i = 0; i < `DVB_SEL_W; i++) begin
			if (sel[i]) begin
				res[8*i +: 8] = new_word[8*i +: 8];
			end
		end
		return res;
	endfunction

	assign access = wb_req.cyc && wb_req.stb && !ack_q; // one ack per two cycles
	assign wr_word = merge_bytes(rd_word, wb_req.dat, wb_req.sel);
	assign wb_rsp = '{ack: ack_q, dat: rdat_q};

	// current contents of the addressed word
	always_comb begin
		case (wb_req.adr)
			`REG_MOD_MODE: rd_word = {{(`DVB_DATA_W-2){1'b0}}, cfg.mod_mode};
			`REG_FREQ_INV: rd_word = {{(`DVB_DATA_W-1){1'b0}}, cfg.freq_inv};
			`REG_SYS_FREQ: rd_word = cfg.sys_freq;
			`REG_BAUD: rd_word = cfg.baud;
			`REG_ENABLE: rd_word = {{(`DVB_DATA_W-1){1'b0}}, cfg.enable};
			`REG_TICK_CNT: rd_word = tick_cnt;
			`REG_LAST_SYM: rd_word = last_sym_q.word;
			default: rd_word = {`DVB_BAD_ADDR_TAG, {(16-`DVB_ADDR_W){1'b0}}, wb_req.adr};
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ack_q <= 1'b0;
			cfg <= '{mod_mode: 2'd0, freq_inv: 1'b0, sys_freq: `RST_SYS_FREQ,
				baud: `RST_BAUD, enable: 1'b0};
		end else begin
			ack_q <= access;
			if (access && wb_req.we) begin
				case (wb_req.adr)
					`REG_MOD_MODE: cfg.mod_mode <= wr_word[1:0];
					`REG_FREQ_INV: cfg.freq_inv <= wr_word[0];
					`REG_SYS_FREQ: cfg.sys_freq <= wr_word;
					`REG_BAUD: cfg.baud <= wr_word;
					`REG_ENABLE: cfg.enable <= wr_word[0];
					default: begin
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (access) begin
			rdat_q <= rd_word;
		end
	end

	// double-rate strobe count
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tick_cnt <= '0;
		end else if (tick_seen) begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			last_sym_q.word <= '0;
		end else if (last_sym_valid) begin
			last_sym_q.sym <= last_sym; // latest sym2x for readback
		end
	end

	a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
		ack_q |=> !ack_q);

	a_ack_after_stb: assert property (@(posedge clk) disable iff (!rst_n)
		ack_q |-> $past(wb_req.cyc && wb_req.stb));

endmodule

`default_nettype wire

//--- source/dvb_s2_baud_gen.sv
`timescale 1ns/10ps
`default_nettype none

module dvb_s2_baud_gen (
	input wire clk,
	input wire rst_n,
	input wire dvb_s2_pkg::mod_cfg_t cfg,
	output logic tick_2x,
	output logic tick_1x
);

	logic [33:0] acc;
	logic [33:0] acc_sum;
	logic [33:0] acc_rem;
	logic hit;
	logic phase;

	// step is twice the baud count per clock
	assign acc_sum = acc + {1'b0, cfg.baud, 1'b0};
	assign acc_rem = acc_sum - {2'b00, cfg.sys_freq};
	assign hit = acc_sum >= {2'b00, cfg.sys_freq};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			acc <= '0;
			phase <= 1'b0;
			tick_2x <= 1'b0;
			tick_1x <= 1'b0;
		end else if (!cfg.enable) begin
			acc <= '0;
			phase <= 1'b0;
			tick_2x <= 1'b0;
			tick_1x <= 1'b0;
		end else begin
			acc <= hit ? acc_rem : acc_sum;
			tick_2x <= hit;
			tick_1x <= hit && !phase; // first of each pair
			if (hit) begin
				phase <= !phase;
			end
		end
	end

	a_tick_nested: assert property (@(posedge clk) disable iff (!rst_n)
		tick_1x |-> tick_2x);

endmodule

`default_nettype wire

//--- source/dvb_s2_mapper.sv
`timescale 1ns/10ps
`default_nettype none

`include "dvb_s2_defines.svh"

module dvb_s2_mapper (
	input wire clk,
	input wire rst_n,
	input wire dvb_s2_pkg::mod_cfg_t cfg,
	input wire tick_1x,
	input wire [7:0] ts_data,
	input wire ts_valid,
	output logic ts_ready,
	output logic sym_valid,
	output dvb_s2_pkg::symbol_t sym
);

	logic [`DVB_BUF_W-1:0] bit_buf; // oldest bit at the top
	logic [4:0] fill;
	logic [4:0] need;
	logic [4:0] fill_taken;
	logic [`DVB_BUF_W-1:0] buf_taken;
	logic is_8psk;
	logic take;
	logic accept;
	logic [2:0] k;
	dvb_s2_pkg::symbol_t point;
	dvb_s2_pkg::symbol_t mapped;

	assign is_8psk = cfg.mod_mode == `DVB_MODE_8PSK;
	assign need = is_8psk ? 5'd3 : 5'd2;
	assign take = tick_1x && (fill >= need); // underflow takes nothing
	assign ts_ready = fill <= 5'd8;
	assign accept = ts_valid && ts_ready;
	assign fill_taken = take ? fill - need : fill;
	assign buf_taken = take ? (bit_buf << need) : bit_buf;

	// gray to binary angle index
	assign k = {bit_buf[15],
		bit_buf[15] ^ bit_buf[14],
		bit_buf[15] ^ bit_buf[14] ^ bit_buf[13]};

	always_comb begin
		point = '0;
		if (is_8psk) begin
			case (k) // k times 45 degrees
				3'd0: point = '{re: `DVB_AMP, im: 16'sd0};
				3'd1: point = '{re: `DVB_QPSK_AMP, im: `DVB_QPSK_AMP};
				3'd2: point = '{re: 16'sd0, im: `DVB_AMP};
				3'd3: point = '{re: -`DVB_QPSK_AMP, im: `DVB_QPSK_AMP};
				3'd4: point = '{re: -`DVB_AMP, im: 16'sd0};
				3'd5: point = '{re: -`DVB_QPSK_AMP, im: -`DVB_QPSK_AMP};
				3'd6: point = '{re: 16'sd0, im: -`DVB_AMP};
				default: point = '{re: `DVB_QPSK_AMP, im: -`DVB_QPSK_AMP};
			endcase
		end else begin
			point.re = bit_buf[15] ? -`DVB_QPSK_AMP : `DVB_QPSK_AMP;
			point.im = bit_buf[14] ? -`DVB_QPSK_AMP : `DVB_QPSK_AMP;
		end
		if (cfg.freq_inv) begin
			mapped.re = point.im; // spectrum inversion
			mapped.im = point.re;
		end else begin
			mapped = point;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bit_buf <= '0;
			fill <= '0;
			sym_valid <= 1'b0;
		end else begin
			bit_buf <= buf_taken;
			fill <= fill_taken;
			if (accept) begin
				// new byte lands right below the remaining bits
				bit_buf <= buf_taken | ({ts_data, 8'h00} >> fill_taken);
				fill <= fill_taken + 5'd8;
			end
			sym_valid <= tick_1x;
		end
	end

	always_ff @(posedge clk) begin
		if (tick_1x) begin
			sym <= take ? mapped : '0;
		end
	end

	a_fill_bound: assert property (@(posedge clk) disable iff (!rst_n)
		fill <= 5'd16);

endmodule

`default_nettype wire

//--- source/dvb_s2_interp.sv
`timescale 1ns/10ps
`default_nettype none

module dvb_s2_interp (
	input wire clk,
	input wire rst_n,
	input wire tick_2x,
	input wire sym_valid,
	input wire dvb_s2_pkg::symbol_t sym,
	output logic sym2x_valid,
	output dvb_s2_pkg::symbol_t sym2x,
	output logic tick_seen
);

	logic tick_d; // tick_2x lined up with mapper output
	dvb_s2_pkg::symbol_t prev_sym;
	dvb_s2_pkg::symbol_t cur_sym;
	dvb_s2_pkg::symbol_t mid_sym;
	logic signed [16:0] sum_re;
	logic signed [16:0] sum_im;

	assign tick_seen = tick_d;

	// midpoint with sign kept
	always_comb begin
		sum_re = prev_sym.re + cur_sym.re;
		sum_im = prev_sym.im + cur_sym.im;
		mid_sym.re = sum_re[16:1];
		mid_sym.im = sum_im[16:1];
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tick_d <= 1'b0;
			sym2x_valid <= 1'b0;
			prev_sym <= '0;
			cur_sym <= '0;
		end else begin
			tick_d <= tick_2x;
			sym2x_valid <= tick_d;
			if (tick_d && sym_valid) begin
				prev_sym <= cur_sym;
				cur_sym <= sym;
			end
		end
	end

	// symbol phase comes with sym_valid, the other phase is the midpoint
	always_ff @(posedge clk) begin
		if (tick_d) begin
			sym2x <= sym_valid ? sym : mid_sym;
		end
	end

endmodule

`default_nettype wire

//--- source/dvb_s2_mod_top.sv
`timescale 1ns/10ps
`default_nettype none

module dvb_s2_mod_top (
	input wire clk,
	input wire rst_n,
	input wire dvb_s2_pkg::wb_req_t wb_req,
	output dvb_s2_pkg::wb_rsp_t wb_rsp,
	input wire [7:0] ts_data,
	input wire ts_valid,
	output logic ts_ready,
	output logic sym1x_valid,
	output dvb_s2_pkg::symbol_t sym1x,
	output logic sym2x_valid,
	output dvb_s2_pkg::symbol_t sym2x
);

	dvb_s2_pkg::mod_cfg_t cfg;
	logic tick_2x;
	logic tick_1x;
	logic tick_seen;

	dvb_s2_cfg_regs dvb_s2_cfg_regs_i (
		.clk(clk),
		.rst_n(rst_n),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.cfg(cfg),
		.tick_seen(tick_seen),
		.last_sym(sym2x), // captured for readback
		.last_sym_valid(sym2x_valid)
	);

	dvb_s2_baud_gen dvb_s2_baud_gen_i (
		.clk(clk),
		.rst_n(rst_n),
		.cfg(cfg),
		.tick_2x(tick_2x),
		.tick_1x(tick_1x)
	);

	dvb_s2_mapper dvb_s2_mapper_i (
		.clk(clk),
		.rst_n(rst_n),
		.cfg(cfg),
		.tick_1x(tick_1x),
		.ts_data(ts_data),
		.ts_valid(ts_valid),
		.ts_ready(ts_ready),
		.sym_valid(sym1x_valid),
		.sym(sym1x)
	);

	dvb_s2_interp dvb_s2_interp_i (
		.clk(clk),
		.rst_n(rst_n),
		.tick_2x(tick_2x),
		.sym_valid(sym1x_valid),
		.sym(sym1x),
		.sym2x_valid(sym2x_valid),
		.sym2x(sym2x),
		.tick_seen(tick_seen)
	);

endmodule

`default_nettype wire

//--- tests/dvb_s2_mod_clkgen.sv
`timescale 1ns/10ps
`default_nettype none

module dvb_s2_mod_clkgen #(
	parameter real PERIOD = 10.0,
	parameter int RST_CYCLES = 3
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2.0) clk = !clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1; // released away from the active edge
	end

endmodule

`default_nettype wire

//--- tests/dvb_s2_mod_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "dvb_s2_defines.svh"

module dvb_s2_mod_tb;

	localparam int CYCLE_LIMIT = 20000;
	localparam logic signed [15:0] AMP = 16'sd32767;
	localparam logic signed [15:0] HALF = 16'sd23170;

	logic clk;
	logic rst_n;
	dvb_s2_pkg::wb_req_t wb_req;
	dvb_s2_pkg::wb_rsp_t wb_rsp;
	logic [7:0] ts_data;
	logic ts_valid;
	logic ts_ready;
	logic sym1x_valid;
	dvb_s2_pkg::symbol_t sym1x;
	logic sym2x_valid;
	dvb_s2_pkg::symbol_t sym2x;

	integer seed = 32'hf711_804f;
	int errors = 0;
	int tests = 0;
	int cycles = 0;
	int sym1x_cnt = 0;
	int sym2x_cnt = 0;
	int zero_cnt = 0;
	int bytes_sent = 0;
	int last_push = 0; // bits offered at the previous falling edge
	bit bits[$]; // sent bits not yet mapped
	logic [1:0] tb_mode = 2'd0;
	logic tb_inv = 1'b0;
	logic src_on = 1'b0;
	logic src_sparse = 1'b0;
	logic [7:0] cur_byte = 8'h00;
	logic prev_sym1x = 1'b0;
	logic [31:0] hist_prev = '0;
	logic [31:0] hist_cur = '0;
	logic [31:0] last_sym2x = '0;

	dvb_s2_mod_clkgen #(.PERIOD(10.0), .RST_CYCLES(3)) dvb_s2_mod_clkgen_i (
		.clk(clk),
		.rst_n(rst_n)
	);

	dvb_s2_mod_top dvb_s2_mod_top_i (
		.clk(clk),
		.rst_n(rst_n),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.ts_data(ts_data),
		.ts_valid(ts_valid),
		.ts_ready(ts_ready),
		.sym1x_valid(sym1x_valid),
		.sym1x(sym1x),
		.sym2x_valid(sym2x_valid),
		.sym2x(sym2x)
	);

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %s got 0x%08h expected 0x%08h", name, got, exp);
			errors++;
		end
	endtask

	// oldest bit sits highest in b
	function automatic logic [31:0] map_bits(input logic [2:0] b, input logic is8,
		input logic inv);
		logic [31:0] p;
		logic [2:0] k;
		if (is8) begin
			k = {b[2], b[2] ^ b[1], b[2] ^ b[1] ^ b[0]};
			case (k)
				3'd0: p = {AMP, 16'sd0};
				3'd1: p = {HALF, HALF};
				3'd2: p = {16'sd0, AMP};
				3'd3: p = {-HALF, HALF};
				3'd4: p = {-AMP, 16'sd0};
				3'd5: p = {-HALF, -HALF};
				3'd6: p = {16'sd0, -AMP};
				default: p = {HALF, -HALF};
			endcase
		end else begin
			p = {(b[1] ? -HALF : HALF), (b[0] ? -HALF : HALF)};
		end
		return inv ? {p[15:0], p[31:16]} : p;
	endfunction

	function automatic logic [31:0] midpoint(input logic [31:0] a, input logic [31:0] b);
		logic signed [16:0] s_re;
		logic signed [16:0] s_im;
		s_re = ($signed(a[31:16]) + $signed(b[31:16])) >>> 1;
		s_im = ($signed(a[15:0]) + $signed(b[15:0])) >>> 1;
		return {s_re[15:0], s_im[15:0]};
	endfunction

	task automatic model_sym2x();
		logic [31:0] exp;
		if (sym2x_valid) begin
			if (prev_sym1x) begin
				exp = hist_cur; // symbol phase
			end else begin
				exp = midpoint(hist_prev, hist_cur);
			end
			check("sym2x", sym2x, exp);
			last_sym2x = exp;
			sym2x_cnt++;
		end
	endtask

	task automatic model_sym1x();
		int need;
		int avail;
		int i;
		logic [2:0] b;
		logic [31:0] exp;
		need = (tb_mode == 2'd1) ? 3 : 2;
		avail = bits.size() - last_push; // bits that had landed at the take edge
		if (sym1x_valid) begin
			if (avail >= need) begin
				b = 3'b000;
				for (i = 0; i < need; i++) begin
					b = {b[1:0], bits.pop_front()};
				end
				exp = map_bits(b, tb_mode == 2'd1, tb_inv);
			end else begin
				exp = '0;
				zero_cnt++;
			end
			check("sym1x", sym1x, exp);
			hist_prev = hist_cur;
			hist_cur = exp;
			sym1x_cnt++;
		end
		prev_sym1x = sym1x_valid;
	endtask

	// a byte is recorded when ready is seen with valid
	task automatic source_step();
		integer r;
		int i;
		last_push = 0;
		check("ts_ready", {31'b0, ts_ready}, {31'b0, bits.size() <= 8});
		r = src_on ? $random(seed) : 0;
		if (!src_on || (src_sparse && r[1:0] != 2'b00)) begin
			ts_valid = 1'b0;
		end else begin
			ts_data = cur_byte;
			ts_valid = 1'b1;
			if (ts_ready) begin
				for (i = 7; i >= 0; i--) begin
					bits.push_back(cur_byte[i]);
				end
				last_push = 8;
				bytes_sent++;
				r = $random(seed);
				cur_byte = r[7:0];
			end
		end
	endtask

	always @(negedge clk) begin
		if (rst_n) begin
			model_sym2x();
			model_sym1x();
			source_step();
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display(">>> FAIL");
			$finish;
		end
	end

	task automatic wb_write(input logic [3:0] adr, input logic [31:0] dat,
		input logic [3:0] sel);
		@(negedge clk);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, sel: sel, dat: dat};
		do @(negedge clk); while (!wb_rsp.ack);
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
		wb_req.we = 1'b0;
	endtask

	task automatic wb_read(input logic [3:0] adr, output logic [31:0] dat);
		@(negedge clk);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, sel: 4'hf, dat: '0};
		do @(negedge clk); while (!wb_rsp.ack);
		dat = wb_rsp.dat;
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
	endtask

	task automatic read_check(input string name, input logic [3:0] adr,
		input logic [31:0] exp);
		logic [31:0] got;
		wb_read(adr, got);
		check(name, got, exp);
	endtask

	task automatic set_mode(input logic [1:0] mode, input logic inv);
		wb_write(`REG_MOD_MODE, {30'b0, mode}, 4'hf);
		wb_write(`REG_FREQ_INV, {31'b0, inv}, 4'hf);
		tb_mode = mode;
		tb_inv = inv;
	endtask

	task automatic wait_symbols(input int n);
		int target;
		target = sym1x_cnt + n;
		while (sym1x_cnt < target) @(negedge clk);
	endtask

	task automatic stop_stream();
		wb_write(`REG_ENABLE, 32'd0, 4'hf);
		src_on = 1'b0;
		src_sparse = 1'b0;
		repeat (6) @(negedge clk); // let the pipeline drain
	endtask

	task automatic stream_test(input logic [1:0] mode, input logic inv, input int n);
		set_mode(mode, inv);
		src_on = 1'b1;
		do @(negedge clk); while (ts_ready); // buffer full before ticks start
		wb_write(`REG_ENABLE, 32'd1, 4'hf);
		wait_symbols(n);
		stop_stream();
	endtask

	task automatic report(input string name, input int err_before);
		tests++;
		$display("test %s: %s", name, (errors == err_before) ? "ok" : "errors");
	endtask

	task automatic test_regs();
		int e;
		e = errors;
		read_check("mod_mode", `REG_MOD_MODE, 32'd0);
		read_check("freq_inv", `REG_FREQ_INV, 32'd0);
		read_check("sys_freq", `REG_SYS_FREQ, 32'd10000);
		read_check("baud", `REG_BAUD, 32'd2500);
		read_check("enable", `REG_ENABLE, 32'd0);
		read_check("tick_cnt", `REG_TICK_CNT, 32'd0);
		read_check("last_sym", `REG_LAST_SYM, 32'd0);
		wb_write(`REG_SYS_FREQ, 32'hAABB_CCDD, 4'b0101);
		read_check("sys_freq", `REG_SYS_FREQ, 32'h00BB_27DD);
		wb_write(`REG_BAUD, 32'h1234_5678, 4'b1000);
		read_check("baud", `REG_BAUD, 32'h1200_09C4);
		wb_write(`REG_ENABLE, 32'd1, 4'b0000); // no byte selected
		read_check("enable", `REG_ENABLE, 32'd0);
		wb_write(`REG_TICK_CNT, 32'hFFFF_FFFF, 4'hf);
		read_check("tick_cnt", `REG_TICK_CNT, 32'd0);
		wb_write(`REG_LAST_SYM, 32'h5555_AAAA, 4'hf);
		read_check("last_sym", `REG_LAST_SYM, 32'd0);
		read_check("unmapped", 4'd7, 32'hE000_0007);
		read_check("unmapped", 4'd15, 32'hE000_000F);
		wb_write(`REG_SYS_FREQ, 32'd10000, 4'hf);
		wb_write(`REG_BAUD, 32'd2500, 4'hf);
		report("register map", e);
	endtask

	task automatic test_rate();
		int e;
		logic [31:0] cnt;
		e = errors;
		wb_write(`REG_SYS_FREQ, 32'd10, 4'hf);
		wb_write(`REG_BAUD, 32'd2, 4'hf);
		wb_write(`REG_ENABLE, 32'd1, 4'hf);
		repeat (500) @(negedge clk);
		wb_read(`REG_TICK_CNT, cnt);
		if (cnt < 32'd198 || cnt > 32'd202) begin
			check("tick_cnt", cnt, 32'd200); // 500 * 4 / 10
		end
		stop_stream();
		wb_write(`REG_SYS_FREQ, 32'd10000, 4'hf);
		wb_write(`REG_BAUD, 32'd2500, 4'hf);
		report("symbol rate", e);
	endtask

	task automatic test_capture();
		int e;
		int n2;
		e = errors;
		n2 = sym2x_cnt;
		stream_test(2'd0, 1'b0, 12);
		check("sym2x count", {31'b0, sym2x_cnt >= n2 + 20}, 32'd1);
		read_check("last_sym", `REG_LAST_SYM, last_sym2x);
		report("interpolation and capture", e);
	endtask

	task automatic test_underflow();
		int e;
		int z;
		int sent;
		e = errors;
		z = zero_cnt;
		set_mode(2'd0, 1'b0);
		wb_write(`REG_ENABLE, 32'd1, 4'hf);
		wait_symbols(12);
		stop_stream();
		if (zero_cnt < z + 4) begin
			$display("underflow produced only %0d zero symbols", zero_cnt - z);
			errors++;
		end
		// fast ticks with a source that holds off most cycles
		sent = bytes_sent;
		wb_write(`REG_SYS_FREQ, 32'd10, 4'hf);
		wb_write(`REG_BAUD, 32'd5, 4'hf);
		src_sparse = 1'b1;
		src_on = 1'b1;
		wb_write(`REG_ENABLE, 32'd1, 4'hf);
		wait_symbols(60);
		stop_stream();
		if (bytes_sent == sent) begin
			$display("held-off source sent no bytes");
			errors++;
		end
		report("underflow and back-pressure", e);
	endtask

	initial begin
		int e;
		wb_req = '0;
		ts_data = 8'h00;
		ts_valid = 1'b0;
		@(posedge rst_n);
		test_regs();
		test_rate();
		e = errors;
		stream_test(2'd0, 1'b0, 40);
		report("qpsk mapping", e);
		e = errors;
		stream_test(2'd1, 1'b1, 40);
		report("8psk with inversion", e);
		test_capture();
		test_underflow();
		$display("tests %0d, symbols %0d, errors %0d", tests, sym1x_cnt, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- dvb_s2_mod_top.f
+incdir+source
source/dvb_s2_pkg.sv
source/dvb_s2_cfg_regs.sv
source/dvb_s2_baud_gen.sv
source/dvb_s2_mapper.sv
source/dvb_s2_interp.sv
source/dvb_s2_mod_top.sv
tests/dvb_s2_mod_clkgen.sv
tests/dvb_s2_mod_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert \
	-f dvb_s2_mod_top.f \
	--top-module dvb_s2_mod_tb \
	-o dvb_s2_mod_sim > build.log 2>&1 \
	&& ./obj_dir/dvb_s2_mod_sim > sim.log 2>&1 \
	|| { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -qx '>>> PASS' sim.log && { echo "simulation passed"; exit 0; } \
	|| { echo "simulation failed, see sim.log"; exit 1; }
